/* list.f */
usb_stream_pkg.sv
mem_cmd_pkg.sv
stream_cmd_parser.sv
word_sram.sv
mem_transfer_ctrl.sv
stream_word_packer.sv
usb_mem_bridge_top.sv
clock_gen.sv
tb_usb_mem_bridge.sv

/* tb_usb_mem_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_usb_mem_bridge;

  localparam int SRAM_WORDS  = 512;
  localparam int MAX_BURST   = 16;
  localparam int CLK_NS      = 20;
  localparam int NUM_ENTRIES = 16;

  typedef struct packed {
    logic [7:0]  opcode;
    logic [7:0]  burst_len;
    logic [15:0] word_addr;
    logic [7:0]  tlast_ofs;  // Signed shift of tlast from the packet end
    logic        err_exp;
  } entry_t;

  logic                  clk;
  logic                  rst_n;
  logic                  run_rst_n;
  logic                  dut_rst_n;
  logic                  s_tvalid_i;
  usb_stream_pkg::byte_t s_tdata_i;
  logic                  s_tlast_i;
  logic                  s_tready_o;
  logic                  m_tvalid_o;
  usb_stream_pkg::byte_t m_tdata_o;
  logic                  m_tlast_o;
  logic                  m_tkeep_o;
  logic                  m_tready_i;
  logic                  cmd_error_o;

  entry_t                tbl [NUM_ENTRIES];
  usb_stream_pkg::word_t ref_mem [SRAM_WORDS];  // Expected memory contents
  usb_stream_pkg::byte_t pkt_buf [256];
  usb_stream_pkg::byte_t exp_data_q [$];
  logic                  exp_last_q [$];
  logic                  err_expected;
  logic                  err_check_pending;
  logic                  table_loaded;
  int                    error_count;
  int                    watchdog_cycles;
  int                    rng_seed;
  int                    rng_dummy;

  clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(3)) i_clock (.clk_o(clk), .rst_n_o(rst_n));

  // Power-on reset, or a reset pulse between error cases
  assign dut_rst_n = rst_n && run_rst_n;

  usb_mem_bridge_top #(
    .SRAM_WORDS(SRAM_WORDS),
    .MAX_BURST (MAX_BURST)
  ) i_dut (
    .bus_clock_i(clk),
    .rst_n_i    (dut_rst_n),
    .s_tvalid_i (s_tvalid_i),
    .s_tdata_i  (s_tdata_i),
    .s_tlast_i  (s_tlast_i),
    .s_tready_o (s_tready_o),
    .m_tvalid_o (m_tvalid_o),
    .m_tdata_o  (m_tdata_o),
    .m_tlast_o  (m_tlast_o),
    .m_tkeep_o  (m_tkeep_o),
    .m_tready_i (m_tready_i),
    .cmd_error_o(cmd_error_o)
  );

  function automatic entry_t make_entry(input logic [7:0] op, input int bl, input int addr,
                                        input int ofs, input logic err);
    entry_t e;
    e.opcode    = op;
    e.burst_len = 8'(bl);
    e.word_addr = 16'(addr);
    e.tlast_ofs = 8'(ofs);
    e.err_exp   = err;
    return e;
  endfunction

  // Header plus write data moved by the tlast offset
  function automatic int packet_length(input entry_t e);
    int len;
    len = 4;
    if (e.opcode == mem_cmd_pkg::OP_WRITE) begin
      len = len + usb_stream_pkg::BYTES_PER_WORD * (int'(e.burst_len) + 1);
    end
    return len + int'($signed(e.tlast_ofs));
  endfunction

  function automatic int response_length(input entry_t e);
    if (e.opcode == mem_cmd_pkg::OP_READ && int'(e.burst_len) < MAX_BURST &&
        e.tlast_ofs == 8'd0) begin
      return usb_stream_pkg::BYTES_PER_WORD * (int'(e.burst_len) + 1);
    end
    return 0;
  endfunction

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_byte(input string name, input usb_stream_pkg::byte_t expected,
                            input usb_stream_pkg::byte_t actual);
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
      abort_run();
    end
  endtask

  // Returns just after the rising edge on which the byte was taken
  task automatic wait_accept();
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = s_tready_o;
      @(posedge clk);
    end
  endtask

  // Waits until every expected response byte has been seen
  task automatic wait_drain();
    int waited;
    int drain_limit;
    drain_limit = 8 * exp_data_q.size() + 100;
    waited      = 0;
    while (exp_data_q.size() != 0 && waited < drain_limit) begin
      @(posedge clk);
      waited++;
    end
    if (exp_data_q.size() != 0) begin
      error_count++;
      $display("Read response incomplete at %0t ns, %0d bytes never arrived",
               $time, exp_data_q.size());
      abort_run();
    end
  endtask

  // Clears the sticky error flag once the pending reads are out, memory keeps its data
  task automatic reset_dut();
    s_tvalid_i <= 1'b0;
    s_tlast_i  <= 1'b0;
    @(posedge clk);
    wait_drain();
    run_rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    run_rst_n         <= 1'b1;
    err_expected      = 1'b0;
    err_check_pending = 1'b1;  // Flag must read low after reset
  endtask

  task automatic send_packet(input entry_t e);
    int len;
    int k;
    int n_words;
    int base;
    usb_stream_pkg::word_t w;
    len        = packet_length(e);
    base       = int'(e.word_addr);
    pkt_buf[0] = e.opcode;
    pkt_buf[1] = e.burst_len;
    pkt_buf[2] = e.word_addr[7:0];   // Address goes little-endian
    pkt_buf[3] = e.word_addr[15:8];
    for (k = 4; k < len; k++) begin
      pkt_buf[k] = usb_stream_pkg::byte_t'($urandom);
    end
    // Whole words of a valid write header reach memory even when framing fails later
    if (e.opcode == mem_cmd_pkg::OP_WRITE && int'(e.burst_len) < MAX_BURST && len >= 4) begin
      n_words = (len - 4) / usb_stream_pkg::BYTES_PER_WORD;
      if (n_words > int'(e.burst_len) + 1) begin
        n_words = int'(e.burst_len) + 1;
      end
      for (k = 0; k < n_words; k++) begin
        ref_mem[(base + k) % SRAM_WORDS] = {pkt_buf[4*k+7], pkt_buf[4*k+6],
                                            pkt_buf[4*k+5], pkt_buf[4*k+4]};
      end
    end
    for (k = 0; k < response_length(e); k++) begin
      w = ref_mem[(base + k / 4) % SRAM_WORDS];
      exp_data_q.push_back(w[8*(k%4) +: 8]);  // LSB first
      exp_last_q.push_back(k == response_length(e) - 1);
    end
    for (k = 0; k < len; k++) begin
      if (k != 0 && ($urandom % 5) == 0) begin
        s_tvalid_i <= 1'b0;
        @(posedge clk);
      end
      s_tvalid_i <= 1'b1;
      s_tdata_i  <= pkt_buf[k];
      s_tlast_i  <= (k == len - 1);
      wait_accept();
    end
    err_expected      = err_expected | e.err_exp;  // Sticky
    err_check_pending = 1'b1;
  endtask

  // Random back-pressure from the BULK IN side
  always @(posedge clk) begin
    if (rst_n) begin
      m_tready_i <= ($urandom % 3) != 0;
    end
  end

  // Response monitor and error flag check at mid-cycle
  always @(negedge clk) begin
    if (rst_n && m_tvalid_o && m_tready_i) begin
      if (exp_data_q.size() == 0) begin
        error_count++;
        $display("Unexpected response byte %h at %0t ns with no read pending", m_tdata_o, $time);
        abort_run();
      end else begin
        check_byte("m_tdata_o", exp_data_q.pop_front(), m_tdata_o);
        check_flag("m_tlast_o", exp_last_q.pop_front(), m_tlast_o);
        check_flag("m_tkeep_o", 1'b1, m_tkeep_o);
      end
    end
    if (err_check_pending) begin
      err_check_pending = 1'b0;
      check_flag("cmd_error_o", err_expected, cmd_error_o);
    end
  end

  initial begin
    wait (table_loaded);
    #(watchdog_cycles * CLK_NS);
    $display("Watchdog expired after %0d clock cycles before the run finished", watchdog_cycles);
    abort_run();
  end

  initial begin
    int i;
    s_tvalid_i        = 1'b0;
    s_tdata_i         = '0;
    s_tlast_i         = 1'b0;
    m_tready_i        = 1'b0;
    run_rst_n         = 1'b1;
    err_expected      = 1'b0;
    err_check_pending = 1'b0;
    table_loaded      = 1'b0;
    error_count       = 0;
    rng_seed          = 89;
    rng_dummy         = $urandom(rng_seed);

    tbl[0]  = make_entry(mem_cmd_pkg::OP_WRITE, 0, 'h0010, 0, 1'b0);  // Single word round trip
    tbl[1]  = make_entry(mem_cmd_pkg::OP_READ, 0, 'h0010, 0, 1'b0);
    tbl[2]  = make_entry(mem_cmd_pkg::OP_WRITE, 15, 'h01F8, 0, 1'b0);  // Wraps to address 0
    tbl[3]  = make_entry(mem_cmd_pkg::OP_READ, 15, 'h01F8, 0, 1'b0);
    tbl[4]  = make_entry(mem_cmd_pkg::OP_WRITE, 15, 'h0100, 0, 1'b0);
    tbl[5]  = make_entry(mem_cmd_pkg::OP_READ, 15, 'h0300, 0, 1'b0);   // Same words modulo 512
    tbl[6]  = make_entry(mem_cmd_pkg::OP_WRITE, 3, 'h0040, 0, 1'b0);
    tbl[7]  = make_entry(mem_cmd_pkg::OP_READ, 3, 'h0040, 0, 1'b0);
    tbl[8]  = make_entry(8'h07, 0, 'h0010, 0, 1'b1);                   // Bad opcode
    tbl[9]  = make_entry(mem_cmd_pkg::OP_READ, 0, 'h0010, 0, 1'b0);
    tbl[10] = make_entry(mem_cmd_pkg::OP_WRITE, 16, 'h0080, 0, 1'b1);  // Burst too long
    tbl[11] = make_entry(mem_cmd_pkg::OP_READ, 3, 'h0040, 0, 1'b0);
    tbl[12] = make_entry(mem_cmd_pkg::OP_WRITE, 3, 'h0020, -6, 1'b1);  // Two whole words land
    tbl[13] = make_entry(mem_cmd_pkg::OP_READ, 1, 'h0020, 0, 1'b0);
    tbl[14] = make_entry(mem_cmd_pkg::OP_WRITE, 1, 'h0000, 3, 1'b1);   // Late tlast
    tbl[15] = make_entry(mem_cmd_pkg::OP_READ, 7, 'h01FC, 0, 1'b0);

    watchdog_cycles = 100;
    for (i = 0; i < NUM_ENTRIES; i++) begin
      watchdog_cycles += 8 * (packet_length(tbl[i]) + response_length(tbl[i]));
    end
    table_loaded = 1'b1;

    @(negedge clk);  // Still in reset
    check_flag("s_tready_o", 1'b1, s_tready_o);
    check_flag("m_tvalid_o", 1'b0, m_tvalid_o);
    check_flag("cmd_error_o", 1'b0, cmd_error_o);
    wait (rst_n);
    @(posedge clk);

    for (i = 0; i < NUM_ENTRIES; i++) begin
      // A flag still set from an earlier error would hide this one
      if (tbl[i].err_exp && err_expected) begin
        reset_dut();
      end
      send_packet(tbl[i]);  // Packets follow each other with no gap
    end
    s_tvalid_i <= 1'b0;
    s_tlast_i  <= 1'b0;

    wait_drain();
    repeat (20) @(posedge clk);  // Extra bytes would show up at the monitor
    @(negedge clk);
    check_flag("m_tvalid_o", 1'b0, m_tvalid_o);
    check_flag("cmd_error_o", err_expected, cmd_error_o);

    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

`default_nettype wire

/* clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset is released on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* usb_mem_bridge_top.sv */
`timescale 1ns/10ps
`default_nettype none

module usb_mem_bridge_top #(
  parameter int SRAM_WORDS = 512,  // Power of two
  parameter int MAX_BURST  = 16
) (
  input  wire                        bus_clock_i,
  input  wire                        rst_n_i,

  // From the BULK OUT side
  input  wire                        s_tvalid_i,
  input  wire usb_stream_pkg::byte_t s_tdata_i,
  input  wire                        s_tlast_i,
  output logic                       s_tready_o,

  // To the BULK IN side
  output logic                       m_tvalid_o,
  output usb_stream_pkg::byte_t      m_tdata_o,
  output logic                       m_tlast_o,
  output logic                       m_tkeep_o,
  input  wire                        m_tready_i,

  output logic                       cmd_error_o
);

  logic                     cmd_valid;
  logic                     cmd_ready;
  mem_cmd_pkg::cmd_header_u cmd;
  logic                     wr_valid;
  usb_stream_pkg::word_t    wr_data;
  logic                     rd_valid;
  usb_stream_pkg::word_t    rd_data;
  logic                     rd_last;
  usb_stream_pkg::credit_t  fifo_free;

  stream_cmd_parser #(
    .MAX_BURST(MAX_BURST)
  ) i_parser (
    .bus_clock_i(bus_clock_i),
    .rst_n_i    (rst_n_i),
    .s_tvalid_i (s_tvalid_i),
    .s_tdata_i  (s_tdata_i),
    .s_tlast_i  (s_tlast_i),
    .s_tready_o (s_tready_o),
    .cmd_valid_o(cmd_valid),
    .cmd_o      (cmd),
    .cmd_ready_i(cmd_ready),
    .wr_valid_o (wr_valid),
    .wr_data_o  (wr_data),
    .cmd_error_o(cmd_error_o)
  );

  mem_transfer_ctrl #(
    .SRAM_WORDS(SRAM_WORDS)
  ) i_ctrl (
    .bus_clock_i(bus_clock_i),
    .rst_n_i    (rst_n_i),
    .cmd_valid_i(cmd_valid),
    .cmd_i      (cmd),
    .cmd_ready_o(cmd_ready),
    .wr_valid_i (wr_valid),
    .wr_data_i  (wr_data),
    .rd_valid_o (rd_valid),
    .rd_data_o  (rd_data),
    .rd_last_o  (rd_last),
    .fifo_free_i(fifo_free)
  );

  stream_word_packer i_packer (
    .bus_clock_i(bus_clock_i),
    .rst_n_i    (rst_n_i),
    .rd_valid_i (rd_valid),
    .rd_data_i  (rd_data),
    .rd_last_i  (rd_last),
    .fifo_free_o(fifo_free),
    .m_tvalid_o (m_tvalid_o),
    .m_tdata_o  (m_tdata_o),
    .m_tlast_o  (m_tlast_o),
    .m_tkeep_o  (m_tkeep_o),
    .m_tready_i (m_tready_i)
  );

endmodule

`default_nettype wire

/* stream_word_packer.sv */
`timescale 1ns/10ps
`default_nettype none

module stream_word_packer (
  input  wire                           bus_clock_i,
  input  wire                           rst_n_i,

  input  wire                           rd_valid_i,
  input  wire usb_stream_pkg::word_t    rd_data_i,
  input  wire                           rd_last_i,
  output usb_stream_pkg::credit_t       fifo_free_o,

  output logic                          m_tvalid_o,
  output usb_stream_pkg::byte_t         m_tdata_o,
  output logic                          m_tlast_o,
  output logic                          m_tkeep_o,
  input  wire                           m_tready_i
);

  localparam int DEPTH = usb_stream_pkg::PACKER_DEPTH;

  usb_stream_pkg::word_t      buf_data_q [DEPTH];
  logic                       buf_last_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
  usb_stream_pkg::credit_t    count_q;
  usb_stream_pkg::byte_idx_t  byte_idx_q;
  logic                       m_fire;
  logic                       word_done;

  assign m_tvalid_o  = count_q != '0;
  assign m_tkeep_o   = m_tvalid_o;  // Every byte of a word is real
  assign m_tdata_o   = buf_data_q[rd_ptr_q][8*byte_idx_q +: 8];
  assign word_done   = byte_idx_q ==
                       usb_stream_pkg::byte_idx_t'(usb_stream_pkg::BYTES_PER_WORD - 1);
  assign m_tlast_o   = buf_last_q[rd_ptr_q] && word_done;
  assign m_fire      = m_tvalid_o && m_tready_i;
  assign fifo_free_o = usb_stream_pkg::credit_t'(DEPTH) - count_q;

  always_ff @(posedge bus_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      byte_idx_q <= '0;
    end else begin
      if (m_fire) begin
        byte_idx_q <= byte_idx_q + 1'b1;  // Walks 0 to 3 and wraps
      end
      if (rd_valid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (m_fire && word_done) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({rd_valid_i, m_fire && word_done})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge bus_clock_i) begin
    if (rd_valid_i) begin
      buf_data_q[wr_ptr_q] <= rd_data_i;
      buf_last_q[wr_ptr_q] <= rd_last_i;
    end
  end

  // Stalled output must hold its byte
  a_out_hold: assert property (@(posedge bus_clock_i) disable iff (!rst_n_i)
    m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o));

endmodule

`default_nettype wire

/* mem_transfer_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_transfer_ctrl #(
  parameter int SRAM_WORDS = 512
) (
  input  wire                           bus_clock_i,
  input  wire                           rst_n_i,

  input  wire                           cmd_valid_i,
  input  wire mem_cmd_pkg::cmd_header_u cmd_i,
  output logic                          cmd_ready_o,

  input  wire                           wr_valid_i,
  input  wire usb_stream_pkg::word_t    wr_data_i,

  output logic                          rd_valid_o,
  output usb_stream_pkg::word_t         rd_data_o,
  output logic                          rd_last_o,
  input  wire usb_stream_pkg::credit_t  fifo_free_i
);

  localparam int ADDR_W = $clog2(SRAM_WORDS);

  typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_READ} state_t;

  state_t                  state_q;
  logic [ADDR_W-1:0]       addr_q;
  mem_cmd_pkg::burst_len_t words_left_q;
  logic                    cmd_take;
  logic                    credit_ok;
  logic                    rd_issue;
  logic                    wr_issue;
  logic                    mem_en;
  logic                    mem_we;
  logic [ADDR_W-1:0]       mem_addr;
  usb_stream_pkg::word_t   mem_wdata;
  usb_stream_pkg::word_t   mem_rdata;

  // A header during a write only shows up after the parser cut that packet short
  assign cmd_ready_o = state_q != ST_READ;
  assign cmd_take    = cmd_valid_i && cmd_ready_o;

  // The read returning this cycle is not yet counted by the packer
  assign credit_ok = fifo_free_i > {1'b0, rd_valid_o};
  assign rd_issue  = (state_q == ST_READ) && credit_ok;
  assign wr_issue  = (state_q == ST_WRITE) && wr_valid_i;

  assign mem_en    = rd_issue || wr_issue;
  assign mem_we    = wr_issue;
  assign mem_addr  = addr_q;
  assign mem_wdata = wr_data_i;
  assign rd_data_o = mem_rdata;

  always_ff @(posedge bus_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= ST_IDLE;
      addr_q       <= '0;
      words_left_q <= '0;
      rd_valid_o   <= 1'b0;
      rd_last_o    <= 1'b0;
    end else begin
      rd_valid_o <= rd_issue;  // SRAM data is ready one cycle later
      rd_last_o  <= rd_issue && (words_left_q == '0);
      if (mem_en) begin
        addr_q       <= addr_q + 1'b1;  // Wraps at the top of memory
        words_left_q <= words_left_q - 1'b1;
        if (words_left_q == '0) begin
          state_q <= ST_IDLE;
        end
      end
      if (cmd_take) begin
        addr_q       <= cmd_i.fields.word_addr[ADDR_W-1:0];
        words_left_q <= cmd_i.fields.burst_len;
        case (cmd_i.fields.opcode)
          mem_cmd_pkg::OP_WRITE: state_q <= ST_WRITE;
          mem_cmd_pkg::OP_READ:  state_q <= ST_READ;
          default:               state_q <= ST_IDLE;
        endcase
      end
    end
  end

  word_sram #(
    .SRAM_WORDS(SRAM_WORDS)
  ) i_sram (
    .bus_clock_i(bus_clock_i),
    .en_i       (mem_en),
    .we_i       (mem_we),
    .addr_i     (mem_addr),
    .wdata_i    (mem_wdata),
    .rdata_o    (mem_rdata)
  );

  // A write word that arrives while reads are issued would be lost
  a_rd_wr_excl: assert property (@(posedge bus_clock_i) disable iff (!rst_n_i)
    !(rd_issue && wr_valid_i));

  // Returned data always finds a free packer entry
  a_credit: assert property (@(posedge bus_clock_i) disable iff (!rst_n_i)
    rd_valid_o |-> fifo_free_i != '0);

endmodule

`default_nettype wire

/* word_sram.sv */
`timescale 1ns/10ps
`default_nettype none

module word_sram #(
  parameter int SRAM_WORDS = 512
) (
  input  wire                            bus_clock_i,

  input  wire                            en_i,
  input  wire                            we_i,
  input  wire [$clog2(SRAM_WORDS)-1:0]   addr_i,
  input  wire usb_stream_pkg::word_t     wdata_i,

  output usb_stream_pkg::word_t          rdata_o
);

  usb_stream_pkg::word_t mem_q [SRAM_WORDS];

  // Registered read, data appears the cycle after the request
  always_ff @(posedge bus_clock_i) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

/* stream_cmd_parser.sv */
`timescale 1ns/10ps
`default_nettype none

module stream_cmd_parser #(
  parameter int MAX_BURST = 16
) (
  input  wire                           bus_clock_i,
  input  wire                           rst_n_i,

  input  wire                           s_tvalid_i,
  input  wire usb_stream_pkg::byte_t    s_tdata_i,
  input  wire                           s_tlast_i,
  output logic                          s_tready_o,

  output logic                          cmd_valid_o,
  output mem_cmd_pkg::cmd_header_u      cmd_o,
  input  wire                           cmd_ready_i,

  output logic                          wr_valid_o,
  output usb_stream_pkg::word_t         wr_data_o,

  output logic                          cmd_error_o
);

  typedef enum logic [1:0] {ST_HDR, ST_DATA, ST_DISCARD} state_t;

  state_t                    state_q;
  usb_stream_pkg::byte_idx_t byte_cnt_q;
  mem_cmd_pkg::burst_len_t   words_left_q;
  mem_cmd_pkg::cmd_header_u  hdr_q;
  usb_stream_pkg::word_t     word_q;
  logic                      s_fire;
  logic                      last_byte;
  logic                      is_read;
  logic                      hdr_ok;

  assign s_tready_o = !cmd_valid_o;  // Stall while a header waits for the controller
  assign s_fire     = s_tvalid_i && s_tready_o;
  assign last_byte  = byte_cnt_q ==
                      usb_stream_pkg::byte_idx_t'(usb_stream_pkg::BYTES_PER_WORD - 1);

  // Bytes 0 and 1 are already stored when byte 3 arrives
  assign is_read = hdr_q.fields.opcode == mem_cmd_pkg::OP_READ;
  assign hdr_ok  = (is_read || hdr_q.fields.opcode == mem_cmd_pkg::OP_WRITE) &&
                   (int'(hdr_q.fields.burst_len) < MAX_BURST);

  assign cmd_o     = hdr_q;
  assign wr_data_o = word_q;

  always_ff @(posedge bus_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= ST_HDR;
      byte_cnt_q   <= '0;
      words_left_q <= '0;
      cmd_valid_o  <= 1'b0;
      wr_valid_o   <= 1'b0;
      cmd_error_o  <= 1'b0;
    end else begin
      wr_valid_o <= 1'b0;
      if (cmd_valid_o && cmd_ready_i) begin
        cmd_valid_o <= 1'b0;
      end
      if (s_fire) begin
        byte_cnt_q <= byte_cnt_q + 1'b1;
        case (state_q)
          ST_HDR: begin
            if (!last_byte) begin
              if (s_tlast_i) begin  // Packet ended inside the header
                cmd_error_o <= 1'b1;
                byte_cnt_q  <= '0;
              end
            end else if (!hdr_ok || (is_read != s_tlast_i)) begin
              cmd_error_o <= 1'b1;
              if (!s_tlast_i) begin
                state_q <= ST_DISCARD;
              end
            end else begin
              cmd_valid_o  <= 1'b1;
              words_left_q <= hdr_q.fields.burst_len;
              if (!is_read) begin
                state_q <= ST_DATA;
              end
            end
          end
          ST_DATA: begin
            if (last_byte) begin
              wr_valid_o   <= 1'b1;  // A whole word is written even when framing is bad
              words_left_q <= words_left_q - 1'b1;
              if (words_left_q == '0) begin
                state_q <= s_tlast_i ? ST_HDR : ST_DISCARD;
                if (!s_tlast_i) begin
                  cmd_error_o <= 1'b1;
                end
              end else if (s_tlast_i) begin
                cmd_error_o <= 1'b1;
                state_q     <= ST_HDR;
              end
            end else if (s_tlast_i) begin  // Partial word is dropped
              cmd_error_o <= 1'b1;
              byte_cnt_q  <= '0;
              state_q     <= ST_HDR;
            end
          end
          default: begin
            if (s_tlast_i) begin
              byte_cnt_q <= '0;
              state_q    <= ST_HDR;
            end
          end
        endcase
      end
    end
  end

  always_ff @(posedge bus_clock_i) begin
    if (s_fire && state_q == ST_HDR) begin
      hdr_q.bytes[byte_cnt_q] <= s_tdata_i;
    end
    if (s_fire && state_q == ST_DATA) begin
      word_q <= {s_tdata_i, word_q[31:8]};  // Least significant byte arrives first
    end
  end

  // A waiting command must not change under the controller
  a_cmd_hold: assert property (@(posedge bus_clock_i) disable iff (!rst_n_i)
    cmd_valid_o && !cmd_ready_i |=> cmd_valid_o && $stable(cmd_o));

endmodule

`default_nettype wire

/* mem_cmd_pkg.sv */
`default_nettype none

package mem_cmd_pkg;

  // Command opcodes, any other value is rejected by the parser
  typedef enum logic [7:0] {
    OP_WRITE = 8'h01,
    OP_READ  = 8'h02
  } opcode_t;

  typedef logic [7:0] burst_len_t;   // Words in the burst minus one
  typedef logic [15:0] word_addr_t;  // Wraps modulo the memory size

  // Listed from the top bit down so the opcode sits in stream byte 0
  typedef struct packed {
    word_addr_t word_addr;  // Bytes 2 and 3, little-endian
    burst_len_t burst_len;  // Byte 1
    opcode_t    opcode;     // Byte 0
  } cmd_fields_t;

  // Filled bytewise by the parser, read as fields by the controller
  typedef union packed {
    cmd_fields_t fields;
    usb_stream_pkg::byte_t [usb_stream_pkg::BYTES_PER_WORD-1:0] bytes;
  } cmd_header_u;

endpackage

`default_nettype wire

/* usb_stream_pkg.sv */
`default_nettype none

package usb_stream_pkg;

  // One byte on the bulk stream
  typedef logic [7:0] byte_t;

  // One word of the on-chip memory
  typedef logic [31:0] word_t;

  localparam int BYTES_PER_WORD = 4;

  // Byte position inside a word, byte 0 travels first
  typedef logic [$clog2(BYTES_PER_WORD)-1:0] byte_idx_t;

  // Words held by the output packer
  localparam int PACKER_DEPTH = 2;

  // Free-entry count of the packer, 0 up to PACKER_DEPTH
  typedef logic [$clog2(PACKER_DEPTH+1)-1:0] credit_t;

endpackage

`default_nettype wire
